// File: src.f
hdl/clause_pkg.sv
hdl/clause_decode.sv
hdl/lit_cell.sv
hdl/lit_pair.sv
hdl/clause_execute.sv
hdl/clause_result.sv
hdl/clause_eval_top.sv
tb/clause_eval_sva.sv
tb/clause_eval_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module clause_eval_tb \
    -f src.f \
    -o clause_eval_sim

./obj_dir/clause_eval_sim

// File: tb/clause_eval_tb.sv
`timescale 1ns/1ns

module clause_eval_tb import clause_pkg::*; ();

    localparam int NUM_LITS    = 4;
    localparam int NUM_CMDS    = 600;
    // about six cycles per command covers back-pressure and the drain.
    localparam int CYCLE_LIMIT = NUM_CMDS * 6 + 400;

    typedef struct packed {
        clause_kind_e            kind;
        var_val_t [NUM_LITS-1:0] vals;
    } expect_t;

    logic         clk;
    logic         rst_n_i;
    logic         valid_i;
    logic         ready_o;
    clause_op_e   op_i;
    lit_word_u    word_i [NUM_LITS];
    logic         valid_o;
    logic         ready_i;
    clause_kind_e kind_o;
    var_val_t     val_o [NUM_LITS];

    logic [31:0]  rng;
    lit_t         model_lits [NUM_LITS];  // clause as the model sees it.
    expect_t      exp_q [$];
    int           cmds_sent;
    int           cycles = 0;
    int           kind_hits [4];

    clause_eval_top #(.NUM_LITS(NUM_LITS)) i_clause_eval_top (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .op_i    (op_i),
        .word_i  (word_i),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .kind_o  (kind_o),
        .val_o   (val_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: no finish after %0d clock cycles", CYCLE_LIMIT));
        end
    end

    task automatic check_kind(input clause_kind_e got, input clause_kind_e exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: kind is %s, expected %s",
                                $time, got.name(), exp.name()));
        end
    endtask

    task automatic check_vals(input var_val_t got [NUM_LITS], input var_val_t exp [NUM_LITS]);
        for (int i = 0; i < NUM_LITS; i++) begin
            if (got[i] !== exp[i]) begin
                abort_run($sformatf("[FAIL] %0t: val slot %0d is %b, expected %b",
                                    $time, i, got[i], exp[i]));
            end
        end
    endtask

    // expected response from the stored literals and the given values.
    task automatic model_eval(input var_val_t vals [NUM_LITS], output expect_t e);
        int   n_free;
        int   free_idx;
        logic sat;
        logic any_used;
        n_free   = 0;
        free_idx = 0;
        sat      = 1'b0;
        any_used = 1'b0;
        for (int i = 0; i < NUM_LITS; i++) begin
            e.vals[i] = vals[i];
            if (model_lits[i].used) begin
                any_used = 1'b1;
                if (!vals[i].assigned) begin
                    n_free   = n_free + 1;
                    free_idx = i;
                end else if (vals[i].value != model_lits[i].neg) begin
                    sat = 1'b1;
                end
            end
        end
        if (sat) begin
            e.kind = KIND_SAT;
        end else if (n_free == 1) begin
            e.kind                    = KIND_UNIT;
            e.vals[free_idx].assigned = 1'b1;
            e.vals[free_idx].value    = ~model_lits[free_idx].neg;
            e.vals[free_idx].implied  = 1'b1;
        end else if (n_free == 0 && any_used) begin
            e.kind = KIND_CONFLICT;
        end else begin
            e.kind = KIND_OPEN;
        end
    endtask

    // roughly one write per four evaluates.
    task automatic new_command();
        rng  = xorshift32(rng);
        op_i = ((rng % 32'd5) == 32'd0) ? OP_WRITE : OP_EVAL;
        for (int i = 0; i < NUM_LITS; i++) begin
            rng = xorshift32(rng);
            if (op_i == OP_WRITE) begin
                word_i[i].as_lit.pad      = 1'b0;
                word_i[i].as_lit.lit.used = rng[5];
                word_i[i].as_lit.lit.neg  = rng[17];
            end else begin
                word_i[i].as_val.assigned = rng[5];
                word_i[i].as_val.value    = rng[17];
                word_i[i].as_val.implied  = 1'b0;
            end
        end
    endtask

    task automatic accept_command();
        var_val_t vals [NUM_LITS];
        expect_t  e;
        cmds_sent = cmds_sent + 1;
        if (op_i == OP_WRITE) begin
            for (int i = 0; i < NUM_LITS; i++) begin
                model_lits[i] = word_i[i].as_lit.lit;
            end
        end else begin
            for (int i = 0; i < NUM_LITS; i++) begin
                vals[i] = word_i[i].as_val;
            end
            model_eval(vals, e);
            exp_q.push_back(e);
        end
    endtask

    task automatic take_response();
        expect_t  e;
        var_val_t exp_vals [NUM_LITS];
        if (exp_q.size() == 0) begin
            abort_run("output transfer seen with no evaluate command pending");
        end
        e = exp_q.pop_front();
        for (int i = 0; i < NUM_LITS; i++) begin
            exp_vals[i] = e.vals[i];
        end
        check_kind(kind_o, e.kind);
        check_vals(val_o, exp_vals);
        kind_hits[int'(e.kind)] = kind_hits[int'(e.kind)] + 1;
    endtask

    initial begin
        logic in_xfer;
        logic out_xfer;
        int   idle;
        rng        = 32'h551;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        ready_i    = 1'b0;
        op_i       = OP_EVAL;
        cmds_sent  = 0;
        idle       = 0;
        for (int i = 0; i < NUM_LITS; i++) begin
            word_i[i]     = '0;
            model_lits[i] = '0;  // cells reset to unused.
        end
        for (int k = 0; k < 4; k++) begin
            kind_hits[k] = 0;
        end

        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        new_command();
        valid_i = 1'b1;
        ready_i = 1'b1;

        // handshakes are judged mid-cycle, where nothing moves.
        while (idle < 8) begin
            @(negedge clk);
            in_xfer  = valid_i & ready_o;
            out_xfer = valid_o & ready_i;
            if (out_xfer) take_response();  // older command first.
            if (in_xfer) accept_command();
            @(posedge clk);
            #1;
            if (in_xfer) begin
                if (cmds_sent < NUM_CMDS) begin
                    new_command();
                end else begin
                    valid_i = 1'b0;
                end
            end
            rng     = xorshift32(rng);
            ready_i = (rng[9:8] != 2'b00);
            if (cmds_sent == NUM_CMDS && exp_q.size() == 0) idle = idle + 1;
        end

        if (kind_hits[0] > 0 && kind_hits[1] > 0 && kind_hits[2] > 0 &&
            kind_hits[3] > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run($sformatf({"not every result kind was seen: ",
                                 "open %0d, sat %0d, unit %0d, conflict %0d"},
                                kind_hits[0], kind_hits[1], kind_hits[2], kind_hits[3]));
        end
    end

endmodule

// File: tb/clause_eval_sva.sv
`timescale 1ns/1ns

module clause_eval_sva import clause_pkg::*; #(
    parameter int NUM_LITS = 4
) (
    input logic         clk,
    input logic         rst_n_i,
    input logic         valid_o,
    input logic         ready_i,
    input clause_kind_e kind_o,
    input var_val_t     val_o [NUM_LITS]
);

    logic [NUM_LITS-1:0]     implied_bits;
    var_val_t [NUM_LITS-1:0] val_flat;

    always_comb begin
        for (int i = 0; i < NUM_LITS; i++) begin
            implied_bits[i] = val_o[i].implied;
            val_flat[i]     = val_o[i];
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n_i |-> !valid_o)
        else $error("valid_o high while in reset");

    // all stages start empty, so nothing leaves before the pipe fills.
    a_reset_exit: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !valid_o ##1 !valid_o ##1 !valid_o)
        else $error("valid_o high before a command could cross the pipeline");

    // stalled output keeps its payload.
    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(kind_o) && $stable(val_flat))
        else $error("output payload changed under back-pressure");

    a_unit_one_implied: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o && kind_o == KIND_UNIT |-> $countones(implied_bits) == 1)
        else $error("unit result without exactly one implied slot");

endmodule

bind clause_result clause_eval_sva #(.NUM_LITS(NUM_LITS)) i_clause_eval_sva (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .kind_o  (kind_o),
    .val_o   (val_o)
);

// File: hdl/clause_eval_top.sv
`timescale 1ns/1ns

module clause_eval_top import clause_pkg::*; #(
    parameter int NUM_LITS = 4
) (
    input  logic         clk,
    input  logic         rst_n_i,

    input  logic         valid_i,
    output logic         ready_o,
    input  clause_op_e   op_i,
    input  lit_word_u    word_i [NUM_LITS],

    output logic         valid_o,
    input  logic         ready_i,
    output clause_kind_e kind_o,
    output var_val_t     val_o [NUM_LITS]
);

    logic        adv;  // shared stall.
    logic        dec_valid;
    clause_op_e  dec_op;
    lit_t        dec_lits [NUM_LITS];
    var_val_t    dec_vals [NUM_LITS];
    exec_flags_t ex_flags;
    var_val_t    ex_val [NUM_LITS];

    assign ready_o = adv;

    clause_decode #(.NUM_LITS(NUM_LITS)) i_clause_decode (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .adv_i   (adv),
        .valid_i (valid_i),
        .op_i    (op_i),
        .word_i  (word_i),
        .valid_o (dec_valid),
        .op_o    (dec_op),
        .lits_o  (dec_lits),
        .vals_o  (dec_vals)
    );

    clause_execute #(.NUM_LITS(NUM_LITS)) i_clause_execute (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .adv_i   (adv),
        .valid_i (dec_valid),
        .op_i    (dec_op),
        .lits_i  (dec_lits),
        .vals_i  (dec_vals),
        .ex_o    (ex_flags),
        .val_o   (ex_val)
    );

    clause_result #(.NUM_LITS(NUM_LITS)) i_clause_result (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .adv_i   (adv),
        .adv_o   (adv),
        .ex_i    (ex_flags),
        .val_i   (ex_val),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .kind_o  (kind_o),
        .val_o   (val_o)
    );

endmodule

// File: hdl/clause_result.sv
`timescale 1ns/1ns

module clause_result import clause_pkg::*; #(
    parameter int NUM_LITS = 4
) (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         adv_i,
    output logic         adv_o,

    input  exec_flags_t  ex_i,
    input  var_val_t     val_i [NUM_LITS],

    output logic         valid_o,
    input  logic         ready_i,
    output clause_kind_e kind_o,
    output var_val_t     val_o [NUM_LITS]
);

    clause_kind_e kind_d;

    always_comb begin
        if (ex_i.sat) begin
            kind_d = KIND_SAT;
        end else if (ex_i.free_cnt == 2'd1) begin
            kind_d = KIND_UNIT;
        end else if (ex_i.free_cnt == 2'd0 && ex_i.any_used) begin
            kind_d = KIND_CONFLICT;
        end else begin
            kind_d = KIND_OPEN;  // also the empty clause.
        end
    end

    // whole pipeline moves when this slot drains or is empty.
    assign adv_o = ~valid_o | ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (adv_i) begin
            valid_o <= ex_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            kind_o <= kind_d;
            for (int i = 0; i < NUM_LITS; i++) begin
                val_o[i] <= val_i[i];
            end
        end
    end

endmodule

// File: hdl/clause_execute.sv
`timescale 1ns/1ns

module clause_execute import clause_pkg::*; #(
    parameter int NUM_LITS = 4
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        adv_i,

    input  logic        valid_i,
    input  clause_op_e  op_i,
    input  lit_t        lits_i [NUM_LITS],
    input  var_val_t    vals_i [NUM_LITS],

    output exec_flags_t ex_o,
    output var_val_t    val_o [NUM_LITS]
);

    localparam int NUM_PAIRS = NUM_LITS / 2;

    logic                 wr;
    free_cnt_t            free_chain [NUM_PAIRS+1];
    free_cnt_t            total_free;
    logic [NUM_PAIRS-1:0] pair_sat;
    logic [NUM_PAIRS-1:0] pair_used;
    var_val_t             cell_val [NUM_LITS];
    logic                 clause_sat;

    // literal registers only move with the pipeline.
    assign wr = valid_i & (op_i == OP_WRITE) & adv_i;

    assign free_chain[0] = 2'd0;
    assign total_free    = free_chain[NUM_PAIRS];

    for (genvar p = 0; p < NUM_PAIRS; p++) begin : g_pair
        lit_pair i_lit_pair (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .wr_i         (wr),
            .lit_i        (lits_i[2*p +: 2]),
            .var_i        (vals_i[2*p +: 2]),
            .var_o        (cell_val[2*p +: 2]),
            .free_pre_i   (free_chain[p]),
            .free_next_o  (free_chain[p+1]),
            .total_free_i (total_free),
            .sat_o        (pair_sat[p]),
            .used_o       (pair_used[p])
        );
    end

    assign clause_sat = |pair_sat;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o <= '0;
        end else if (adv_i) begin
            ex_o.valid    <= valid_i & (op_i == OP_EVAL);  // writes leave a bubble.
            ex_o.sat      <= clause_sat;
            ex_o.any_used <= |pair_used;
            ex_o.free_cnt <= total_free;
        end
    end

    // a satisfied clause implies nothing, so values pass unchanged.
    always_ff @(posedge clk) begin
        if (adv_i) begin
            for (int i = 0; i < NUM_LITS; i++) begin
                val_o[i] <= clause_sat ? vals_i[i] : cell_val[i];
            end
        end
    end

endmodule

// File: hdl/lit_pair.sv
`timescale 1ns/1ns

module lit_pair import clause_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      wr_i,
    input  lit_t      lit_i [2],

    input  var_val_t  var_i [2],
    output var_val_t  var_o [2],

    input  free_cnt_t free_pre_i,
    output free_cnt_t free_next_o,
    input  free_cnt_t total_free_i,

    output logic      sat_o,
    output logic      used_o
);

    free_cnt_t  free_mid;
    logic [1:0] sat;
    logic [1:0] used;

    lit_cell i_lit_cell_0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wr_i         (wr_i),
        .lit_i        (lit_i[0]),
        .var_i        (var_i[0]),
        .free_pre_i   (free_pre_i),
        .free_next_o  (free_mid),
        .total_free_i (total_free_i),
        .sat_o        (sat[0]),
        .used_o       (used[0]),
        .var_o        (var_o[0])
    );

    lit_cell i_lit_cell_1 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wr_i         (wr_i),
        .lit_i        (lit_i[1]),
        .var_i        (var_i[1]),
        .free_pre_i   (free_mid),  // chained from the first cell.
        .free_next_o  (free_next_o),
        .total_free_i (total_free_i),
        .sat_o        (sat[1]),
        .used_o       (used[1]),
        .var_o        (var_o[1])
    );

    assign sat_o  = |sat;
    assign used_o = |used;

endmodule

// File: hdl/lit_cell.sv
`timescale 1ns/1ns

module lit_cell import clause_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      wr_i,
    input  lit_t      lit_i,

    input  var_val_t  var_i,
    input  free_cnt_t free_pre_i,
    output free_cnt_t free_next_o,
    input  free_cnt_t total_free_i,

    output logic      sat_o,
    output logic      used_o,
    output var_val_t  var_o
);

    lit_t lit_q;
    logic free;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lit_q <= '0;  // slot unused.
        end else if (wr_i) begin
            lit_q <= lit_i;
        end
    end

    assign used_o = lit_q.used;
    assign sat_o  = lit_q.used & var_i.assigned & (var_i.value ^ lit_q.neg);
    assign free   = lit_q.used & ~var_i.assigned;

    // count up, stick at two.
    assign free_next_o = (free && free_pre_i != 2'd2) ? free_pre_i + 2'd1 : free_pre_i;

    always_comb begin
        var_o = var_i;
        if (free && total_free_i == 2'd1) begin  // sole free literal.
            var_o.assigned = 1'b1;
            var_o.value    = ~lit_q.neg;
            var_o.implied  = 1'b1;
        end
    end

endmodule

// File: hdl/clause_decode.sv
`timescale 1ns/1ns

module clause_decode import clause_pkg::*; #(
    parameter int NUM_LITS = 4
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       adv_i,

    input  logic       valid_i,
    input  clause_op_e op_i,
    input  lit_word_u  word_i [NUM_LITS],

    output logic       valid_o,
    output clause_op_e op_o,
    output lit_t       lits_o [NUM_LITS],
    output var_val_t   vals_o [NUM_LITS]
);

    lit_t     lits_d [NUM_LITS];
    var_val_t vals_d [NUM_LITS];

    // each word is read through the view its opcode selects.
    always_comb begin
        for (int i = 0; i < NUM_LITS; i++) begin
            if (op_i == OP_WRITE) begin
                lits_d[i] = word_i[i].as_lit.lit;
                vals_d[i] = '0;
            end else begin
                lits_d[i] = '0;
                vals_d[i] = word_i[i].as_val;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            op_o    <= OP_WRITE;
        end else if (adv_i) begin
            valid_o <= valid_i;
            op_o    <= op_i;
        end
    end

    // payload only, follows the valid flag.
    always_ff @(posedge clk) begin
        if (adv_i) begin
            for (int i = 0; i < NUM_LITS; i++) begin
                lits_o[i] <= lits_d[i];
                vals_o[i] <= vals_d[i];
            end
        end
    end

endmodule

// File: hdl/clause_pkg.sv
package clause_pkg;

    // one stored literal slot.
    typedef struct packed {
        logic used;
        logic neg;  // set for the negated variable.
    } lit_t;

    // state of the variable behind one slot.
    typedef struct packed {
        logic assigned;
        logic value;
        logic implied;  // assignment produced by this clause.
    } var_val_t;

    // literal view of a payload slot, padded to the value width.
    typedef struct packed {
        logic pad;
        lit_t lit;
    } lit_view_t;

    // one slot of command payload, decoded by opcode.
    typedef union packed {
        var_val_t  as_val;  // evaluate commands.
        lit_view_t as_lit;  // write commands.
    } lit_word_u;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_EVAL  = 1'b1
    } clause_op_e;

    // saturating free literal count, 2 means two or more.
    typedef logic [1:0] free_cnt_t;

    typedef enum logic [1:0] {
        KIND_OPEN     = 2'd0,
        KIND_SAT      = 2'd1,
        KIND_UNIT     = 2'd2,
        KIND_CONFLICT = 2'd3
    } clause_kind_e;

    // clause flags handed from execute to result.
    typedef struct packed {
        logic      valid;
        logic      sat;
        logic      any_used;
        free_cnt_t free_cnt;
    } exec_flags_t;

endpackage
